/* Bender.yml */
package:
  name: la_capture

sources:
  - rtl/la_pkg.sv
  - rtl/sample_mem_if.sv
  - rtl/change_sampler.sv
  - rtl/la_ctrl.sv
  - rtl/sample_ram.sv
  - rtl/uart_tx.sv
  - rtl/la_top.sv
  - target: test
    files:
      - dv/la_assert.sv
      - dv/la_tb.sv

/* dv/la_assert.sv */
// Concurrent checks on the capture controller and the UART transmitter.
// The same checker is bound into both modules; an input that has no
// counterpart in a target is tied to a constant.

`timescale 1ns/1ps

module la_assert (
  input logic clk_i,
  input logic rst_in,
  input logic stb_i,       // transmit strobe
  input logic rdy_i,       // transmitter ready
  input logic we_i,        // sample memory write
  input logic readout_i,   // controller in tx or tx_wait
  input logic line_i       // serial line
);

  stb_needs_rdy: assert property (@(posedge clk_i) disable iff (!rst_in) stb_i |-> rdy_i)
    else $error("transmit strobe while transmitter busy");

  no_write_in_readout: assert property (
    @(posedge clk_i) disable iff (!rst_in) readout_i |-> !we_i
  ) else $error("sample memory written during readout");

  idle_line_high: assert property (@(posedge clk_i) disable iff (!rst_in) rdy_i |-> line_i)
    else $error("serial line low while transmitter idle");

endmodule

bind la_ctrl la_assert u_ctrl_assert (
  .clk_i     (clk_i),
  .rst_in    (rst_in),
  .stb_i     (tx_stb_o),
  .rdy_i     (tx_rdy_i),
  .we_i      (mem.we),
  .readout_i (state_q == la_pkg::tx || state_q == la_pkg::tx_wait),
  .line_i    (1'b1)
);

bind uart_tx la_assert u_uart_assert (
  .clk_i     (clk_i),
  .rst_in    (rst_in),
  .stb_i     (stb_i),
  .rdy_i     (rdy_o),
  .we_i      (1'b0),
  .readout_i (1'b0),
  .line_i    (tx_o)
);

/* dv/la_tb.sv */
// Testbench for the logic-analyzer capture core.
// Runs a table of capture and readout passes, decodes the UART line into
// 32-bit words and compares them with a model of the stored sample history.

`timescale 1ns/1ps

module la_tb;

  localparam int clks_per_bit = 4;

  logic            clk_i = 1'b0;
  logic            rst_in;
  la_pkg::sample_t probe_i;
  logic            set_cnt_i;
  la_pkg::cmd_t    cmd_i;
  logic            run_i;
  logic            busy_o;
  logic            uart_tx_o;

  string           name_q[$];
  int              pre_q[$];
  int              dly_q[$];
  int              rd_q[$];
  int              post_q[$];
  bit              load_q[$];
  bit              rep_q[$];
  la_pkg::sample_t hist[$];                       // written samples, oldest first
  la_pkg::sample_t rx_q[$];                       // words decoded from the line
  int              mismatch_cnt = 0;
  int              fail_cnt = 0;
  int              cycle_cnt = 0;
  int              cycle_limit = 0;

  la_top #(.CLKS_PER_BIT(clks_per_bit)) dut (.*);

  always #5 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > cycle_limit) begin
      $display("timeout after %0d cycles, %0d mismatches, %0d other errors",
               cycle_cnt, mismatch_cnt, fail_cnt);
      $display("Errors found");
      $finish;
    end
  end

  // dly and rd are the counts in force for the row whether loaded or not
  task automatic add_row(input string name, input int pre, input bit load, input int dly,
                         input int rd, input int post, input bit rep);
    name_q.push_back(name);
    pre_q.push_back(pre);
    load_q.push_back(load);
    dly_q.push_back(dly);
    rd_q.push_back(rd);
    post_q.push_back(post);
    rep_q.push_back(rep);
  endtask

  task automatic check_sample(input string name, input la_pkg::sample_t exp_v,
                              input la_pkg::sample_t act_v);
    if (act_v !== exp_v) begin
      mismatch_cnt++;
      $display("MISMATCH %s: expected %h, actual %h", name, exp_v, act_v);
    end
  endtask

  task automatic check_count(input string name, input la_pkg::cnt_t exp_v,
                             input la_pkg::cnt_t act_v);
    if (act_v !== exp_v) begin
      mismatch_cnt++;
      $display("MISMATCH %s: expected %0d words, actual %0d", name, exp_v, act_v);
    end
  endtask

  task automatic apply_changes(input int n, input bit rep);
    la_pkg::sample_t v;
    for (int i = 0; i < n; i++) begin
      v = $urandom;
      while (v == probe_i) begin
        v = $urandom;                             // keep consecutive values distinct
      end
      @(posedge clk_i);
      #1 probe_i = v;
      hist.push_back(v);
      if (hist.size() > la_pkg::mem_depth) begin
        void'(hist.pop_front());
      end
      repeat (2) @(posedge clk_i);
      if (rep) begin
        #1 probe_i = v;                           // held value makes no new sample
        repeat (3) @(posedge clk_i);
      end
    end
  endtask

  // mid-bit sampling on the falling clock edge
  initial begin : uart_decoder
    logic [7:0]      byte_v;
    la_pkg::sample_t word_v;
    int              nbytes;
    nbytes = 0;
    word_v = '0;
    forever begin
      @(negedge clk_i);
      if (rst_in === 1'b1 && uart_tx_o === 1'b0) begin
        repeat (clks_per_bit / 2) @(negedge clk_i);
        if (uart_tx_o !== 1'b0) begin
          fail_cnt++;
          $display("start bit did not stay low at mid-bit");
        end
        for (int b = 0; b < 8; b++) begin
          repeat (clks_per_bit) @(negedge clk_i);
          byte_v[b] = uart_tx_o;                  // lsb first
        end
        repeat (clks_per_bit) @(negedge clk_i);
        if (uart_tx_o !== 1'b1) begin
          fail_cnt++;
          $display("stop bit missing after a UART byte");
        end
        word_v[nbytes*8 +: 8] = byte_v;
        nbytes++;
        if (nbytes == 4) begin
          rx_q.push_back(word_v);
          nbytes = 0;
        end
      end
    end
  end

  initial begin : main
    int n;
    void'($urandom(5));
    add_row("first_run", 0, 0, 1, 1, 1, 0);       // reset counts
    add_row("dly3_rd5", 2, 1, 3, 5, 3, 0);
    add_row("rd_zero", 1, 1, 2, 0, 2, 0);
    add_row("wrap_rd32", 38, 1, 2, 32, 2, 0);
    add_row("repeat_hold", 3, 1, 1, 4, 1, 1);
    cycle_limit = 200;
    foreach (name_q[r]) begin
      cycle_limit += (pre_q[r] + post_q[r]) * 6 + rd_q[r] * 40 * clks_per_bit + 40;
    end

    rst_in    = 1'b0;
    probe_i   = '0;
    set_cnt_i = 1'b0;
    cmd_i     = '0;
    run_i     = 1'b0;
    repeat (5) @(posedge clk_i);
    #1 rst_in = 1'b1;

    foreach (name_q[r]) begin
      rx_q.delete();
      if (load_q[r]) begin
        @(posedge clk_i);
        #1 set_cnt_i = 1'b1;
        cmd_i = {16'(rd_q[r]), 16'(dly_q[r])};
        @(posedge clk_i);
        #1 set_cnt_i = 1'b0;
      end
      apply_changes(pre_q[r], rep_q[r]);
      @(posedge clk_i);
      #1 run_i = 1'b1;
      @(posedge clk_i);
      #1 run_i = 1'b0;
      apply_changes(post_q[r], rep_q[r]);         // exactly the delay count
      @(negedge clk_i);
      while (busy_o) @(negedge clk_i);            // readout ends when busy falls

      check_count(name_q[r], la_pkg::cnt_t'(rd_q[r]), la_pkg::cnt_t'(rx_q.size()));
      for (int k = 0; k < rx_q.size() && k < hist.size(); k++) begin
        check_sample(name_q[r], hist[hist.size() - 1 - k], rx_q[k]);  // newest first
      end
      n = (rd_q[r] < hist.size()) ? rd_q[r] : hist.size();
      repeat (n) void'(hist.pop_back());          // pointer walked back over these
    end

    $display("done: %0d mismatches, %0d other errors", mismatch_cnt, fail_cnt);
    if (mismatch_cnt == 0 && fail_cnt == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

/* files.f */
rtl/la_pkg.sv
rtl/sample_mem_if.sv
rtl/change_sampler.sv
rtl/la_ctrl.sv
rtl/sample_ram.sv
rtl/uart_tx.sv
rtl/la_top.sv
dv/la_assert.sv
dv/la_tb.sv

/* rtl/change_sampler.sv */
// Transitional sampler for the probe bus.
// Every time the probe differs from the last captured value, the new value
// is registered and a one-cycle strobe marks it as a fresh sample.
// The captured value holds until the next change.

`timescale 1ns/1ps

module change_sampler (
  input  logic            clk_i,
  input  logic            rst_in,
  input  la_pkg::sample_t probe_i,
  output la_pkg::sample_t smpl_o,
  output logic            stb_o
);

  la_pkg::sample_t last_q;   // last distinct value seen
  logic            stb_q;

  always_ff @(posedge clk_i) begin
    if (!rst_in) begin
      last_q <= '0;          // first nonzero probe counts as a change
      stb_q  <= 1'b0;
    end else begin
      if (probe_i != last_q) begin
        last_q <= probe_i;
        stb_q  <= 1'b1;
      end else begin
        stb_q  <= 1'b0;
      end
    end
  end

  assign smpl_o = last_q;
  assign stb_o  = stb_q;

endmodule

/* rtl/la_ctrl.sv */
// Capture, trigger and readout controller.
// In idle and trig every sampler strobe is written at a circular pointer.
// A run pulse arms the trigger; after the delay count of further samples
// the controller walks the pointer backwards and hands the read count of
// words, newest first, to the UART transmitter.

`timescale 1ns/1ps

module la_ctrl (
  input  logic               clk_i,
  input  logic               rst_in,
  input  logic               set_cnt_i,
  input  la_pkg::cmd_t       cmd_i,
  input  logic               run_i,
  input  logic               stb_i,
  input  la_pkg::sample_t    smpl_i,
  input  logic               tx_rdy_i,
  output logic               busy_o,
  output logic               tx_stb_o,
  output la_pkg::sample_t    tx_word_o,
  sample_mem_if.ctrl         mem
);

  la_pkg::ctrl_state_t state_q, state_d;
  la_pkg::addr_t       ptr_q, ptr_d;      // next write slot
  la_pkg::cnt_t        cnt_q, cnt_d;      // delay or readout progress
  la_pkg::cnt_t        rd_cnt_q;
  la_pkg::cnt_t        dly_cnt_q;

  always_comb begin
    state_d  = state_q;
    ptr_d    = ptr_q;
    cnt_d    = cnt_q;
    mem.we   = 1'b0;
    mem.addr = ptr_q;
    tx_stb_o = 1'b0;

    case (state_q)
      la_pkg::idle: begin
        if (run_i) begin
          state_d = la_pkg::trig;
          cnt_d   = '0;
        end
        if (stb_i) begin
          mem.we = 1'b1;
          ptr_d  = ptr_q + la_pkg::addr_t'(1);
        end
      end

      la_pkg::trig: begin
        // leaving wins over a same-cycle strobe so the delay stays exact
        if (cnt_q == dly_cnt_q) begin
          state_d = la_pkg::tx;
          cnt_d   = '0;
        end else if (stb_i) begin
          mem.we = 1'b1;
          ptr_d  = ptr_q + la_pkg::addr_t'(1);
          cnt_d  = cnt_q + la_pkg::cnt_t'(1);
        end
      end

      la_pkg::tx: begin
        if (cnt_q == rd_cnt_q) begin
          state_d = la_pkg::idle;
        end else begin
          state_d  = la_pkg::tx_wait;
          cnt_d    = cnt_q + la_pkg::cnt_t'(1);
          ptr_d    = ptr_q - la_pkg::addr_t'(1);
          mem.addr = ptr_q - la_pkg::addr_t'(1); // newest unread word
          tx_stb_o = 1'b1;
        end
      end

      la_pkg::tx_wait: begin
        if (tx_rdy_i) begin
          state_d = la_pkg::tx;
        end
      end

      default: state_d = la_pkg::idle;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_in) begin
      state_q <= la_pkg::idle;
      ptr_q   <= '0;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      ptr_q   <= ptr_d;
      cnt_q   <= cnt_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_in) begin
      rd_cnt_q  <= la_pkg::cnt_t'(1);
      dly_cnt_q <= la_pkg::cnt_t'(1);
    end else if (set_cnt_i) begin
      rd_cnt_q  <= {1'b0, cmd_i[31:16]};
      dly_cnt_q <= {1'b0, cmd_i[15:0]};
    end
  end

  assign mem.wdata = smpl_i;                // current sample from the sampler
  assign tx_word_o = mem.rdata;
  assign busy_o    = (state_q != la_pkg::idle);

endmodule

/* rtl/la_pkg.sv */
// Shared types for the logic-analyzer capture core.
// Holds the sample and address widths, the command layout and the
// controller state encoding. Modules refer to these by scoped name.

package la_pkg;

  localparam int mem_depth = 32;                  // sample memory entries

  typedef logic [31:0] sample_t;                  // one probe sample / memory word
  typedef logic [4:0]  addr_t;                    // sample memory address
  typedef logic [31:0] cmd_t;                     // [31:16] read count, [15:0] delay
  typedef logic [16:0] cnt_t;                     // count field, one bit wider

  typedef enum logic [1:0] {
    idle,                                         // capturing, waiting for run
    trig,                                         // armed, counting post-trigger samples
    tx,                                           // fetch next word for readout
    tx_wait                                       // wait for the transmitter
  } ctrl_state_t;

endpackage

/* rtl/la_top.sv */
// Top level of the logic-analyzer capture core.
// The probe bus is sampled on every change and stored in a circular memory.
// A command sets the post-trigger delay and the read count, run arms the
// trigger, and the captured history is sent back over uart_tx_o.

`timescale 1ns/1ps

module la_top #(
  parameter int CLKS_PER_BIT = 16
) (
  input  logic            clk_i,
  input  logic            rst_in,
  input  la_pkg::sample_t probe_i,
  input  logic            set_cnt_i,
  input  la_pkg::cmd_t    cmd_i,
  input  logic            run_i,
  output logic            busy_o,
  output logic            uart_tx_o
);

  la_pkg::sample_t smpl;
  logic            stb;
  logic            tx_stb;
  la_pkg::sample_t tx_word;
  logic            tx_rdy;

  sample_mem_if mem_if ();

  change_sampler u_sampler (
    .clk_i   (clk_i),
    .rst_in  (rst_in),
    .probe_i (probe_i),
    .smpl_o  (smpl),
    .stb_o   (stb)
  );

  la_ctrl u_ctrl (
    .clk_i     (clk_i),
    .rst_in    (rst_in),
    .set_cnt_i (set_cnt_i),
    .cmd_i     (cmd_i),
    .run_i     (run_i),
    .stb_i     (stb),
    .smpl_i    (smpl),
    .tx_rdy_i  (tx_rdy),
    .busy_o    (busy_o),
    .tx_stb_o  (tx_stb),
    .tx_word_o (tx_word),
    .mem       (mem_if.ctrl)
  );

  sample_ram u_ram (
    .clk_i (clk_i),
    .mem   (mem_if.mem)
  );

  uart_tx #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) u_uart (
    .clk_i  (clk_i),
    .rst_in (rst_in),
    .stb_i  (tx_stb),
    .word_i (tx_word),
    .rdy_o  (tx_rdy),
    .tx_o   (uart_tx_o)
  );

endmodule

/* rtl/sample_mem_if.sv */
// Connection between the capture controller and the sample memory.
// The controller drives the write strobe, the address and the write data;
// the memory returns the word at the current address.

`timescale 1ns/1ps

interface sample_mem_if;

  logic            we;      // write strobe
  la_pkg::addr_t   addr;    // shared read/write address
  la_pkg::sample_t wdata;   // sample to store
  la_pkg::sample_t rdata;   // word at addr

  modport ctrl (
    output we,
    output addr,
    output wdata,
    input  rdata
  );

  modport mem (
    input  we,
    input  addr,
    input  wdata,
    output rdata
  );

endinterface

/* rtl/sample_ram.sv */
// Circular sample memory of mem_depth 32-bit words.
// Writes take effect at the clock edge; the read port is combinational so
// the controller can present a word in the same cycle it addresses it.

`timescale 1ns/1ps

module sample_ram (
  input  logic   clk_i,
  sample_mem_if.mem mem
);

  la_pkg::sample_t ram_q [la_pkg::mem_depth];

  always_ff @(posedge clk_i) begin
    if (mem.we) begin
      ram_q[mem.addr] <= mem.wdata;
    end
  end

  assign mem.rdata = ram_q[mem.addr];    // async read

endmodule

/* rtl/uart_tx.sv */
// UART transmitter for 32-bit words.
// A strobe latches the word, which then goes out as four 8N1 frames,
// least significant byte first. Each bit lasts CLKS_PER_BIT clock cycles.
// rdy_o is high only while the line is idle.

`timescale 1ns/1ps

module uart_tx #(
  parameter int CLKS_PER_BIT = 16
) (
  input  logic            clk_i,
  input  logic            rst_in,
  input  logic            stb_i,
  input  la_pkg::sample_t word_i,
  output logic            rdy_o,
  output logic            tx_o
);

  localparam int clk_w     = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
  localparam int last_bit  = 9;                          // stop bit index
  localparam int last_byte = $bits(la_pkg::sample_t) / 8 - 1;

  logic                busy_q;
  logic [clk_w-1:0]    clk_cnt_q;                        // cycles within a bit
  logic [3:0]          bit_idx_q;                        // 0 start, 1..8 data, 9 stop
  logic [1:0]          byte_idx_q;
  logic                tx_q;
  la_pkg::sample_t     word_q;
  logic [7:0]          cur_byte;

  assign cur_byte = word_q[byte_idx_q*8 +: 8];

  always_ff @(posedge clk_i) begin
    if (!busy_q && stb_i) begin
      word_q <= word_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_in) begin
      busy_q     <= 1'b0;
      clk_cnt_q  <= '0;
      bit_idx_q  <= '0;
      byte_idx_q <= '0;
      tx_q       <= 1'b1;
    end else if (!busy_q) begin
      if (stb_i) begin
        busy_q     <= 1'b1;
        clk_cnt_q  <= '0;
        bit_idx_q  <= '0;
        byte_idx_q <= '0;
        tx_q       <= 1'b0;                              // start bit of byte 0
      end
    end else if (clk_cnt_q == clk_w'(CLKS_PER_BIT - 1)) begin
      clk_cnt_q <= '0;
      if (bit_idx_q == 4'(last_bit)) begin
        bit_idx_q <= '0;
        if (byte_idx_q == 2'(last_byte)) begin
          busy_q <= 1'b0;                                // line stays high
        end else begin
          byte_idx_q <= byte_idx_q + 2'd1;
          tx_q       <= 1'b0;
        end
      end else begin
        bit_idx_q <= bit_idx_q + 4'd1;
        if (bit_idx_q == 4'(last_bit - 1)) begin
          tx_q <= 1'b1;                                  // stop bit
        end else begin
          tx_q <= cur_byte[bit_idx_q[2:0]];              // lsb first
        end
      end
    end else begin
      clk_cnt_q <= clk_cnt_q + clk_w'(1);
    end
  end

  assign rdy_o = !busy_q;
  assign tx_o  = tx_q;

endmodule
